/* verilog/busMasterPkg.sv */
`default_nettype none

package busMasterPkg;

    ////////////////////////////////////////
    // memory geometry
    ////////////////////////////////////////

    localparam int MEMORY_DEPTH = 4096;
    localparam int DATA_WIDTH = 16;
    localparam int ADDRESS_WIDTH = $clog2(MEMORY_DEPTH);

    ////////////////////////////////////////
    // frame layout
    ////////////////////////////////////////

    // leading ones that open every frame
    localparam int START_MARKER_LEN = 3;
    // marker + slave id
    localparam int REQUEST_LEN = 5;
    // marker + slave id + rdWr + address
    localparam int CONTROL_LEN = 18;
    // consecutive high arbCont samples for a grant
    localparam int GRANT_CYCLES = 2;

    typedef logic [ADDRESS_WIDTH-1:0] addrT;
    typedef logic [DATA_WIDTH-1:0] dataT;
    typedef logic [1:0] slaveIdT;
    typedef logic [CONTROL_LEN-1:0] controlFrameT;
    // wide enough for a word or a control frame
    typedef logic [4:0] bitCountT;

endpackage

`default_nettype wire

/* verilog/localRam.sv */
`timescale 1ns/10ps
`default_nettype none

module localRam import busMasterPkg::*; (
    input  wire        clk,
    input  wire        wr,
    input  wire addrT  ramAddress,
    input  wire dataT  ramData,
    output dataT       q
);

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    // contents undefined until written
    dataT mem [MEMORY_DEPTH];

    // read-first, one cycle latency
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[ramAddress] <= ramData;
        end
        q <= mem[ramAddress];
    end

endmodule

`default_nettype wire

/* verilog/wordSender.sv */
`timescale 1ns/10ps
`default_nettype none

module wordSender import busMasterPkg::*; (
    input  wire        clk,
    input  wire        rstN,
    input  wire        load,
    input  wire dataT  word,
    input  wire        ready,
    output logic       wrD,
    output logic       busy
);

    dataT shiftReg;
    bitCountT count;
    logic advance;

    assign advance = busy && ready;

    // MSB of the shift register is the bit on the wire
    assign wrD = busy && shiftReg[DATA_WIDTH-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
            count <= '0;
        end else if (load) begin
            busy <= 1'b1;
            count <= '0;
        end else if (advance) begin
            if (count == bitCountT'(DATA_WIDTH - 1)) begin
                busy <= 1'b0;
                count <= '0;
            end else begin
                count <= count + bitCountT'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shiftReg <= word;
        end else if (advance) begin
            shiftReg <= {shiftReg[DATA_WIDTH-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* verilog/wordReceiver.sv */
`timescale 1ns/10ps
`default_nettype none

module wordReceiver import busMasterPkg::*; (
    input  wire   clk,
    input  wire   rstN,
    input  wire   enable,
    input  wire   ready,
    input  wire   rD,
    output dataT  word,
    output logic  wordDone
);

    bitCountT count;
    logic shiftIn;

    // hold off during the wordDone cycle so the word stays put
    assign shiftIn = enable && ready && !wordDone;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
            wordDone <= 1'b0;
        end else begin
            wordDone <= 1'b0;
            if (!enable) begin
                count <= '0;
            end else if (shiftIn) begin
                if (count == bitCountT'(DATA_WIDTH - 1)) begin
                    count <= '0;
                    wordDone <= 1'b1;
                end else begin
                    count <= count + bitCountT'(1);
                end
            end
        end
    end

    // MSB first, so new bits enter at the bottom
    always_ff @(posedge clk) begin
        if (shiftIn) begin
            word <= {word[DATA_WIDTH-2:0], rD};
        end
    end

endmodule

`default_nettype wire

/* verilog/transactionSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module transactionSequencer import busMasterPkg::*; (
    input  wire           clk,
    input  wire           rstN,

    // host
    input  wire           start,
    input  wire           rdWr,
    input  wire           inEx,
    input  wire slaveIdT  slaveId,
    input  wire addrT     address,
    input  wire dataT     data,

    // arbiter
    input  wire           arbCont,

    // sender / receiver
    input  wire           busy,
    input  wire dataT     word,
    input  wire           wordDone,

    // memory read data
    input  wire dataT     q,

    output logic          arbSend,
    output logic          control,
    output logic          valid,
    output logic          load,
    output logic          enable,
    output logic          wr,
    output addrT          ramAddress,
    output dataT          ramData,
    output logic          doneCom,
    output dataT          dataOut
);

    typedef enum logic [2:0] {
        stIdle,
        stLoad,
        stRequest,
        stGrantWait,
        stControl,
        stFetch,
        stData,
        stFinish
    } seqStateT;

    seqStateT state;
    bitCountT bitCount;
    logic savedRdWr;
    logic savedInEx;
    addrT savedAddress;
    dataT savedData;

    // frames as built from the host inputs, and their shift copies
    logic [REQUEST_LEN-1:0] requestFrame;
    logic [REQUEST_LEN-1:0] requestShift;
    controlFrameT controlFrame;
    controlFrameT controlShift;

    // arbCont history plus current sample
    logic [GRANT_CYCLES-2:0] arbHistory;
    logic [GRANT_CYCLES-1:0] grantWindow;

    logic dataDone;

    assign requestFrame = {{START_MARKER_LEN{1'b1}}, slaveId};
    assign controlFrame = {{START_MARKER_LEN{1'b1}}, slaveId, rdWr, address};
    assign grantWindow = {arbHistory, arbCont};

    // write ends when the sender goes idle, read when a word is assembled
    assign dataDone = savedRdWr ? !busy : wordDone;

    ////////////////////////////////////////
    // datapath strobes
    ////////////////////////////////////////

    // valid drops in the cycle right after the last bit moved
    assign valid = (state == stData) && !dataDone;
    assign load = (state == stFetch);
    assign enable = (state == stData) && !savedRdWr;
    assign doneCom = (state == stFinish);

    // host word goes in during stLoad, received word at the end of a read
    assign wr = ((state == stLoad) && savedInEx && savedRdWr) ||
                ((state == stData) && !savedRdWr && wordDone);
    assign ramAddress = savedAddress;
    assign ramData = (state == stLoad) ? savedData : word;

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stIdle;
            bitCount <= '0;
            savedRdWr <= 1'b0;
            savedInEx <= 1'b0;
            arbHistory <= '0;
            arbSend <= 1'b0;
            control <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (start) begin
                        savedRdWr <= rdWr;
                        savedInEx <= inEx;
                        // first request bit is out in the next cycle
                        arbSend <= requestFrame[REQUEST_LEN-1];
                        bitCount <= bitCountT'(1);
                        state <= stLoad;
                    end
                end
                // stLoad is also the first request bit cycle
                stLoad, stRequest: begin
                    if (bitCount == bitCountT'(REQUEST_LEN)) begin
                        arbSend <= 1'b0;
                        arbHistory <= '0;
                        state <= stGrantWait;
                    end else begin
                        arbSend <= requestShift[REQUEST_LEN-1];
                        bitCount <= bitCount + bitCountT'(1);
                        state <= stRequest;
                    end
                end
                stGrantWait: begin
                    arbHistory <= grantWindow[GRANT_CYCLES-2:0];
                    if (&grantWindow) begin
                        arbSend <= 1'b1;
                        control <= controlShift[CONTROL_LEN-1];
                        bitCount <= bitCountT'(1);
                        state <= stControl;
                    end
                end
                stControl: begin
                    if (bitCount == bitCountT'(CONTROL_LEN)) begin
                        control <= 1'b0;
                        // writes need one cycle to hand q to the sender
                        state <= savedRdWr ? stFetch : stData;
                    end else begin
                        control <= controlShift[CONTROL_LEN-1];
                        bitCount <= bitCount + bitCountT'(1);
                    end
                end
                stFetch: begin
                    state <= stData;
                end
                stData: begin
                    if (dataDone) begin
                        arbSend <= 1'b0;
                        state <= stFinish;
                    end
                end
                stFinish: begin
                    state <= stIdle;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // frame shifters and saved host words
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        case (state)
            stIdle: begin
                if (start) begin
                    requestShift <= {requestFrame[REQUEST_LEN-2:0], 1'b0};
                    controlShift <= controlFrame;
                    savedAddress <= address;
                    savedData <= data;
                end
            end
            stLoad, stRequest: begin
                requestShift <= {requestShift[REQUEST_LEN-2:0], 1'b0};
            end
            stGrantWait: begin
                if (&grantWindow) begin
                    controlShift <= {controlShift[CONTROL_LEN-2:0], 1'b0};
                end
            end
            stControl: begin
                controlShift <= {controlShift[CONTROL_LEN-2:0], 1'b0};
            end
            stData: begin
                // q still holds the fetched word on a write
                if (dataDone) begin
                    dataOut <= savedRdWr ? q : word;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/busMaster.sv */
`timescale 1ns/10ps
`default_nettype none

module busMaster import busMasterPkg::*; (
    input  wire           clk,
    input  wire           rstN,

    // host side
    input  wire           start,
    input  wire           rdWr,
    input  wire           inEx,
    input  wire slaveIdT  slaveId,
    input  wire addrT     address,
    input  wire dataT     data,
    output logic          doneCom,
    output dataT          dataOut,

    // slave side
    input  wire           rD,
    input  wire           ready,
    output logic          control,
    output logic          wrD,
    output logic          valid,

    // arbiter side
    input  wire           arbCont,
    output logic          arbSend
);

    // sender handshake
    logic load;
    logic busy;

    // receiver handshake
    logic enable;
    dataT rxWord;
    logic wordDone;

    // memory port
    logic wr;
    addrT ramAddress;
    dataT ramData;
    dataT q;

    transactionSequencer sequencer_i (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .rdWr       (rdWr),
        .inEx       (inEx),
        .slaveId    (slaveId),
        .address    (address),
        .data       (data),
        .arbCont    (arbCont),
        .busy       (busy),
        .word       (rxWord),
        .wordDone   (wordDone),
        .q          (q),
        .arbSend    (arbSend),
        .control    (control),
        .valid      (valid),
        .load       (load),
        .enable     (enable),
        .wr         (wr),
        .ramAddress (ramAddress),
        .ramData    (ramData),
        .doneCom    (doneCom),
        .dataOut    (dataOut)
    );

    // outgoing word comes straight from the memory read port
    wordSender sender_i (
        .clk   (clk),
        .rstN  (rstN),
        .load  (load),
        .word  (q),
        .ready (ready),
        .wrD   (wrD),
        .busy  (busy)
    );

    wordReceiver receiver_i (
        .clk      (clk),
        .rstN     (rstN),
        .enable   (enable),
        .ready    (ready),
        .rD       (rD),
        .word     (rxWord),
        .wordDone (wordDone)
    );

    localRam ram_i (
        .clk        (clk),
        .wr         (wr),
        .ramAddress (ramAddress),
        .ramData    (ramData),
        .q          (q)
    );

endmodule

`default_nettype wire

/* tb/busMasterChecker.sv */
`timescale 1ns/10ps
`default_nettype none

module busMasterChecker import busMasterPkg::*; (
    input  wire           clk,
    input  wire           rstN,
    input  wire           start,
    input  wire           rdWr,
    input  wire           inEx,
    input  wire slaveIdT  slaveId,
    input  wire addrT     address,
    input  wire dataT     data,
    input  wire           rD,
    input  wire           ready,
    input  wire           arbCont,
    input  wire           doneCom,
    input  wire dataT     dataOut,
    input  wire           control,
    input  wire           wrD,
    input  wire           valid,
    input  wire           arbSend,
    output int            errorCount,
    output int            doneCount
);

    typedef enum {phIdle, phRequest, phGrant, phControl, phData} phaseT;

    phaseT phase = phIdle;
    int errors = 0;
    int finished = 0;
    int count;
    int highRun;
    int bitsMoved;
    logic resetSeen = 1'b0;

    // transaction as accepted from the host
    logic txWrite;
    logic txHost;
    slaveIdT txId;
    addrT txAddr;
    dataT txData;

    logic [REQUEST_LEN-1:0] reqBits;
    controlFrameT ctrlBits;
    dataT wireWord;
    dataT expected;
    dataT modelMem [MEMORY_DEPTH];

    assign errorCount = errors;
    assign doneCount = finished;

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // word that has to cross the data phase
    function automatic dataT expectedWord(input logic isWrite, input logic useHost,
                                          input dataT hostWord, input dataT memWord,
                                          input dataT slaveWord);
        if (!isWrite) begin
            return slaveWord;
        end
        if (useHost) begin
            return hostWord;
        end
        return memWord;
    endfunction

    function automatic string testName(input string what);
        if (!txWrite) begin
            return {"read ", what};
        end
        return txHost ? {"write inEx ", what} : {"write ", what};
    endfunction

    task automatic compare(input string name, input logic [31:0] want,
                           input logic [31:0] got);
        if (got !== want) begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, want, got);
            errors++;
        end
    endtask

    task automatic complain(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        errors++;
    endtask

    ////////////////////////////////////////
    // port monitor
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (!rstN) begin
            // first edge may still show power-up values
            if (resetSeen && ({doneCom, arbSend, control, valid, wrD} !== 5'b0)) begin
                complain("DUT outputs are not low during reset");
            end
            resetSeen = 1'b1;
            phase = phIdle;
        end else begin
            case (phase)
                phIdle: begin
                    if (doneCom) begin
                        complain("doneCom pulsed outside a transaction");
                    end
                    if (start) begin
                        txWrite = rdWr;
                        txHost = inEx;
                        txId = slaveId;
                        txAddr = address;
                        txData = data;
                        count = 0;
                        phase = phRequest;
                    end
                end
                phRequest: begin
                    reqBits = {reqBits[REQUEST_LEN-2:0], arbSend};
                    count++;
                    if (control) begin
                        complain("control is high during the request frame");
                    end
                    if (count == REQUEST_LEN) begin
                        compare(testName("request frame"),
                                32'({{START_MARKER_LEN{1'b1}}, txId}), 32'(reqBits));
                        highRun = 0;
                        phase = phGrant;
                    end
                end
                phGrant: begin
                    if (control) begin
                        if (highRun < GRANT_CYCLES) begin
                            complain("control frame started before the grant");
                        end
                        if (valid || !arbSend) begin
                            complain("valid or arbSend wrong at the first control bit");
                        end
                        ctrlBits = controlFrameT'(1);
                        count = 1;
                        phase = phControl;
                    end else begin
                        if (highRun >= GRANT_CYCLES) begin
                            complain("no control frame after the grant");
                        end
                        highRun = arbCont ? highRun + 1 : 0;
                    end
                end
                phControl: begin
                    ctrlBits = {ctrlBits[CONTROL_LEN-2:0], control};
                    count++;
                    if (valid || !arbSend) begin
                        complain("valid or arbSend wrong during the control frame");
                    end
                    if (count == CONTROL_LEN) begin
                        compare(testName("control frame"),
                                32'({{START_MARKER_LEN{1'b1}}, txId, txWrite, txAddr}),
                                32'(ctrlBits));
                        bitsMoved = 0;
                        wireWord = '0;
                        phase = phData;
                    end
                end
                phData: begin
                    if (doneCom) begin
                        expected = expectedWord(txWrite, txHost, txData, modelMem[txAddr],
                                                wireWord);
                        compare(testName("bit count"), 32'(DATA_WIDTH), 32'(bitsMoved));
                        if (txWrite) begin
                            compare(testName("wrD word"), 32'(expected), 32'(wireWord));
                        end
                        compare(testName("dataOut"), 32'(expected), 32'(dataOut));
                        if (!txWrite) begin
                            modelMem[txAddr] = wireWord;
                        end else if (txHost) begin
                            modelMem[txAddr] = txData;
                        end
                        finished++;
                        phase = phIdle;
                    end else begin
                        if (!arbSend) begin
                            complain("arbSend dropped before doneCom");
                        end
                        // a bit crosses only when both sides agree
                        if (valid && ready) begin
                            wireWord = {wireWord[DATA_WIDTH-2:0], txWrite ? wrD : rD};
                            bitsMoved++;
                        end
                    end
                end
                default: begin
                    phase = phIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* tb/busMasterTb.sv */
`timescale 1ns/10ps
`default_nettype none

module busMasterTb import busMasterPkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 8;
    localparam int DIRECTED_COUNT = 4;
    localparam int RANDOM_COUNT = 40;
    localparam int NUM_TRANSACTIONS = DIRECTED_COUNT + RANDOM_COUNT;
    // request, grant wait, control frame and a slow data phase
    localparam int TXN_BOUND_CYCLES = 300;
    localparam int TIMEOUT_NS = (RESET_CYCLES + NUM_TRANSACTIONS * TXN_BOUND_CYCLES) * CLK_PERIOD;

    logic clk;
    logic rstN;
    logic start;
    logic rdWr;
    logic inEx;
    slaveIdT slaveId;
    addrT address;
    dataT data;
    logic rD;
    logic ready;
    logic arbCont;
    logic doneCom;
    dataT dataOut;
    logic control;
    logic wrD;
    logic valid;
    logic arbSend;
    int errorCount;
    int doneCount;
    integer seed = 32'he4c8643a;

    busMaster busMaster_i (.*);

    busMasterChecker checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // arbiter and slave models
    ////////////////////////////////////////

    // reads the request frame, then grants after a random delay
    initial begin : arbiterModel
        int arbPhase;
        int arbCount;
        arbCont <= 1'b0;
        arbPhase = 0;
        arbCount = 0;
        forever begin
            @(posedge clk);
            case (arbPhase)
                0: begin
                    if (arbSend) begin
                        arbCount = 1;
                        arbPhase = 1;
                    end
                end
                1: begin
                    arbCount++;
                    if (arbCount == REQUEST_LEN) begin
                        arbCount = $unsigned($random(seed)) % 6;
                        arbPhase = 2;
                    end
                end
                2: begin
                    if (arbCount == 0) begin
                        arbCont <= 1'b1;
                        arbPhase = 3;
                    end else begin
                        arbCount--;
                    end
                end
                default: begin
                    if (doneCom) begin
                        arbCont <= 1'b0;
                        arbPhase = 0;
                    end
                end
            endcase
        end
    end

    // new read word per transaction, ready low about a quarter of the time
    initial begin : slaveModel
        dataT slaveWord;
        slaveWord = dataT'($random(seed));
        ready <= 1'b0;
        rD <= slaveWord[DATA_WIDTH-1];
        forever begin
            @(posedge clk);
            ready <= ($unsigned($random(seed)) % 4) != 0;
            if (doneCom) begin
                slaveWord = dataT'($random(seed));
            end else if (valid && ready) begin
                slaveWord = {slaveWord[DATA_WIDTH-2:0], 1'b0};
            end
            rD <= slaveWord[DATA_WIDTH-1];
        end
    end

    ////////////////////////////////////////
    // host stimulus
    ////////////////////////////////////////

    task automatic runTransaction(input logic isWrite, input logic useHost, input slaveIdT id,
                                  input addrT addr, input dataT word);
        start <= 1'b1;
        rdWr <= isWrite;
        inEx <= useHost;
        slaveId <= id;
        address <= addr;
        data <= word;
        @(posedge clk);
        start <= 1'b0;
        do begin
            @(posedge clk);
        end while (!doneCom);
    endtask

    initial begin : stimulus
        addrT knownAddr [$];
        addrT pick;
        int kind;
        rstN <= 1'b0;
        start <= 1'b0;
        rdWr <= 1'b0;
        inEx <= 1'b0;
        slaveId <= '0;
        address <= '0;
        data <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);

        // host word out, slave word in, then both sent back from memory
        runTransaction(1'b1, 1'b1, 2'd1, 12'h0a5, 16'hbeef);
        runTransaction(1'b0, 1'b0, 2'd2, 12'h3c0, 16'h0000);
        runTransaction(1'b1, 1'b0, 2'd3, 12'h3c0, 16'h1234);
        runTransaction(1'b1, 1'b0, 2'd0, 12'h0a5, 16'h5678);
        knownAddr.push_back(12'h0a5);
        knownAddr.push_back(12'h3c0);

        // plain writes only go to addresses that hold a known word
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            kind = $unsigned($random(seed)) % 3;
            if (kind == 2) begin
                pick = knownAddr[$unsigned($random(seed)) % knownAddr.size()];
                runTransaction(1'b1, 1'b0, slaveIdT'($random(seed)), pick,
                               dataT'($random(seed)));
            end else begin
                pick = addrT'($random(seed));
                knownAddr.push_back(pick);
                runTransaction(kind == 1, kind == 1, slaveIdT'($random(seed)), pick,
                               dataT'($random(seed)));
            end
        end

        repeat (2) @(posedge clk);
        $display("%0d of %0d transactions checked, %0d errors", doneCount, NUM_TRANSACTIONS,
                 errorCount);
        if (errorCount == 0 && doneCount == NUM_TRANSACTIONS) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: transactions did not complete within %0d ns", TIMEOUT_NS);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
verilog/busMasterPkg.sv
verilog/localRam.sv
verilog/wordSender.sv
verilog/wordReceiver.sv
verilog/transactionSequencer.sv
verilog/busMaster.sv
tb/busMasterChecker.sv
tb/busMasterTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := busMasterTb
FILELIST  := all.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0 --top-module $(TOP)
LINTFLAGS := --lint-only --timing -Wall --top-module $(TOP)
PASS_MSG  := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
